// ==== rtl/sprite_defs.svh ====
// raster, sprite and walk constants for the 160x120 test raster
// coordinates are signed 16-bit; sync pulses are active high
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// horizontal timing in pixels
`define H_ACTIVE        16'sd160
`define H_TOTAL         16'sd200
`define HS_START        16'sd168
`define HS_END          16'sd184

// vertical timing in lines
`define V_ACTIVE        16'sd120
`define V_TOTAL         16'sd130
`define VS_START        16'sd122
`define VS_END          16'sd124

`define SPR_W           16          // source pixels per sprite row
`define SPR_H           8           // source rows
`define SPR_FRAMES      3           // animation frames in the ROM
`define SPR_SCALE       2           // same factor in x and y
`define SPR_START_X     16'sd160
`define SPR_Y           16'sd40
`define SPR_SPEED       16'sd4      // pixels per frame
`define SPR_LEFT_LIMIT  (-16'sd40)  // wrap once at or left of this
`define SPR_TRANS       9           // transparent palette index
`define ANIM_PERIOD     4           // frames per animation step

`endif

// ==== rtl/sprite_pkg.sv ====
// shared types and the ROM and palette fill rules
// the rules must stay in step with the model in the testbench
`default_nettype none

package sprite_pkg;

`include "sprite_defs.svh"

    typedef logic signed [15:0] coord_t;   // screen coordinate
    typedef logic [3:0]         colr_idx_t;
    typedef logic [8:0]         spr_addr_t; // 3 frames of 16x8

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef enum logic [2:0] {
        IDLE,       // waiting for start
        REG_POS,    // latch position, clear row counters
        ACTIVE,     // current pixel is inside the sprite
        WAIT_POS,   // waiting for the first column
        LINE,       // rest of the row, row decision at its end
        DONE
    } spr_state_t;

    // graphic entry at frame f, row y, column x
    function automatic colr_idx_t spr_rom_rule(input int f, input int y, input int x);
        if ((x + y) % 5 == 0) begin
            return colr_idx_t'(`SPR_TRANS);
        end
        return colr_idx_t'(3 * f + x + 2 * y);
    endfunction

    function automatic rgb_t palette_rule(input colr_idx_t i);
        rgb_t c;
        c.r = i;
        c.g = 4'd15 - i;
        c.b = 4'(5 * i);  // low bits only
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/raster_if.sv ====
// raster position and strobes shared by the pixel-clock blocks
// all signals change on clk_pix; line and frame are one-cycle strobes
`default_nettype none
`timescale 1ns/1ps

interface raster_if
    import sprite_pkg::*;
();

    coord_t sx;     // column, 0 at left edge
    coord_t sy;     // row, 0 at top
    logic   hsync;
    logic   vsync;
    logic   de;     // active area
    logic   line;   // sx == 0, every row
    logic   frame;  // sx == 0 and sy == 0

    modport producer (
        output sx, sy, hsync, vsync, de, line, frame
    );

    modport consumer (
        input sx, sy, hsync, vsync, de, line, frame
    );

endinterface

`default_nettype wire

// ==== rtl/display_timings.sv ====
// raster counter for the reduced 160x120 timing
// outputs decode straight from the counters, no pipeline stage
`default_nettype none
`timescale 1ns/1ps

`include "sprite_defs.svh"

module display_timings
    import sprite_pkg::*;
(
    input  wire logic  clk_pix,
    input  wire logic  reset,
    raster_if.producer raster
);

    coord_t sx;
    coord_t sy;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == `H_TOTAL - 1) begin
            sx <= '0;
            sy <= (sy == `V_TOTAL - 1) ? '0 : coord_t'(sy + 1);  // wrap at frame end
        end else begin
            sx <= coord_t'(sx + 1);
        end
    end

    assign raster.sx    = sx;
    assign raster.sy    = sy;
    assign raster.de    = (sx < `H_ACTIVE) && (sy < `V_ACTIVE);
    assign raster.hsync = (sx >= `HS_START) && (sx < `HS_END);  // active high
    assign raster.vsync = (sy >= `VS_START) && (sy < `VS_END);

    // strobes on the first cycle of each row and of each frame
    assign raster.line  = (sx == 0);
    assign raster.frame = (sx == 0) && (sy == 0);

endmodule

`default_nettype wire

// ==== rtl/sprite_rom.sv ====
// sprite graphic ROM, one cycle from addr to data
// filled from spr_rom_rule; addresses past the last frame read undefined
`default_nettype none
`timescale 1ns/1ps

`include "sprite_defs.svh"

module sprite_rom
    import sprite_pkg::*;
(
    input  wire logic      clk_pix,
    input  wire spr_addr_t addr,
    output colr_idx_t      data
);

    localparam int FRAME_PIX = `SPR_W * `SPR_H;
    localparam int DEPTH     = `SPR_FRAMES * FRAME_PIX;

    colr_idx_t mem [0:DEPTH-1];

    initial begin
        for (int f = 0; f < `SPR_FRAMES; f++) begin
            for (int y = 0; y < `SPR_H; y++) begin
                for (int x = 0; x < `SPR_W; x++) begin
                    mem[f * FRAME_PIX + y * `SPR_W + x] = spr_rom_rule(f, y, x);
                end
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        data <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== rtl/sprite_animator.sv ====
// walk position and animation frame, both updated on the frame strobe
// start fires one row above SPR_Y so the engine can fetch ahead of column 0
`default_nettype none
`timescale 1ns/1ps

`include "sprite_defs.svh"

module sprite_animator
    import sprite_pkg::*;
(
    input  wire logic  clk_pix,
    input  wire logic  reset,
    raster_if.consumer raster,
    output coord_t     sprx,
    output coord_t     spry,
    output spr_addr_t  base_addr,
    output logic       start
);

    localparam int ANIM_W = $clog2(`ANIM_PERIOD);

    logic [ANIM_W-1:0] anim_cnt;   // frames within one animation step
    logic [1:0]        frame_sel;  // graphic frame 0..SPR_FRAMES-1

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sprx      <= `SPR_START_X;
            anim_cnt  <= '0;
            frame_sel <= '0;
        end else if (raster.frame) begin
            // walk right to left, restart once fully past the left edge
            sprx <= (sprx <= `SPR_LEFT_LIMIT) ? `SPR_START_X : coord_t'(sprx - `SPR_SPEED);
            if (anim_cnt == ANIM_W'(`ANIM_PERIOD - 1)) begin
                anim_cnt  <= '0;
                frame_sel <= (frame_sel == 2'(`SPR_FRAMES - 1)) ? '0 : frame_sel + 1'b1;
            end else begin
                anim_cnt <= anim_cnt + 1'b1;
            end
        end
    end

    assign spry = `SPR_Y;  // fixed height for the walk

    // engine arms on the row above the sprite
    assign start = raster.line && (raster.sy == spry - 1);

    assign base_addr = spr_addr_t'(frame_sel * (`SPR_W * `SPR_H));

endmodule

`default_nettype wire

// ==== rtl/sprite_engine.sv ====
// draws the sprite scaled by SPR_SCALE, rows starting one line after start
// ROM address leads the raster by one cycle; left-edge clipping handled,
// sprite must end before H_TOTAL
`default_nettype none
`timescale 1ns/1ps

`include "sprite_defs.svh"

module sprite_engine
    import sprite_pkg::*;
(
    input  wire logic      clk_pix,
    input  wire logic      reset,
    raster_if.consumer     raster,
    input  wire logic      start,
    input  wire coord_t    sprx,
    input  wire colr_idx_t rom_data,
    output spr_addr_t      pos,
    output colr_idx_t      pix,
    output logic           drawing,
    output logic           done
);

    localparam int SPR_PIX_W = `SPR_W * `SPR_SCALE;  // scaled width
    localparam int COLW      = $clog2(`SPR_W);
    localparam int ROWW      = $clog2(`SPR_H);
    localparam int SCW       = $clog2(`SPR_SCALE);

    spr_state_t      state, state_n;
    coord_t          spr_x;          // position latched for this sprite
    coord_t          ofs;            // scaled column that lands on sx 0
    logic [COLW-1:0] col, col_n;     // source column
    logic [SCW-1:0]  cnt_x, cnt_x_n;
    logic [ROWW-1:0] row, row_n;     // source row about to be drawn
    logic [SCW-1:0]  cnt_y, cnt_y_n;
    logic [ROWW-1:0] row_inc;
    logic [SCW-1:0]  cnt_y_inc;
    logic            last_row;

    always_comb begin
        ofs      = -spr_x;
        last_row = (row == ROWW'(`SPR_H - 1)) && (cnt_y == SCW'(`SPR_SCALE - 1));
        if (cnt_y == SCW'(`SPR_SCALE - 1)) begin
            row_inc   = row + 1'b1;
            cnt_y_inc = '0;
        end else begin
            row_inc   = row;        // repeat the source row
            cnt_y_inc = cnt_y + 1'b1;
        end

        state_n = state;
        col_n   = col;
        cnt_x_n = cnt_x;
        row_n   = row;
        cnt_y_n = cnt_y;

        case (state)
            IDLE: begin
                if (start) begin
                    state_n = REG_POS;
                end
            end
            REG_POS: begin
                state_n = LINE;
                row_n   = '0;
                cnt_y_n = '0;
            end
            LINE: begin
                // decide the next row on the last cycle of this one
                if (raster.sx == `H_TOTAL - 1) begin
                    if (spr_x > 0) begin
                        state_n = WAIT_POS;
                    end else if (ofs < SPR_PIX_W) begin
                        state_n = ACTIVE;  // partly off the left edge
                        col_n   = COLW'(ofs / `SPR_SCALE);
                        cnt_x_n = SCW'(ofs % `SPR_SCALE);
                    end else begin
                        state_n = last_row ? DONE : LINE;  // row fully hidden
                        row_n   = row_inc;
                        cnt_y_n = cnt_y_inc;
                    end
                end
            end
            WAIT_POS: begin
                if (raster.sx == spr_x - 1) begin
                    state_n = ACTIVE;
                    col_n   = '0;
                    cnt_x_n = '0;
                end
            end
            ACTIVE: begin
                if (cnt_x == SCW'(`SPR_SCALE - 1)) begin
                    cnt_x_n = '0;
                    if (col == COLW'(`SPR_W - 1)) begin
                        state_n = last_row ? DONE : LINE;
                        row_n   = row_inc;
                        cnt_y_n = cnt_y_inc;
                    end else begin
                        col_n = col + 1'b1;
                    end
                end else begin
                    cnt_x_n = cnt_x + 1'b1;
                end
            end
            DONE: begin
                state_n = IDLE;
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= IDLE;
            col   <= '0;
            cnt_x <= '0;
            row   <= '0;
            cnt_y <= '0;
        end else begin
            state <= state_n;
            col   <= col_n;
            cnt_x <= cnt_x_n;
            row   <= row_n;
            cnt_y <= cnt_y_n;
        end
        if (state == REG_POS) begin
            spr_x <= sprx;
        end
    end

    // fetch for the next cycle, so data lines up with the raster
    assign pos = spr_addr_t'(row_n * `SPR_W + col_n);

    assign drawing = (state == ACTIVE);
    assign pix     = drawing ? rom_data : '0;
    assign done    = (state == DONE);  // one cycle after the last row

endmodule

`default_nettype wire

// ==== rtl/pixel_compositor.sv ====
// background bands, palette lookup and transparency, one register stage
// colour is forced to zero outside de
`default_nettype none
`timescale 1ns/1ps

`include "sprite_defs.svh"

module pixel_compositor
    import sprite_pkg::*;
(
    input  wire logic      clk_pix,
    input  wire logic      reset,
    raster_if.consumer     raster,
    input  wire colr_idx_t pix,
    input  wire logic      drawing,
    output logic [3:0]     red,
    output logic [3:0]     green,
    output logic [3:0]     blue,
    output logic           hsync,
    output logic           vsync,
    output logic           de
);

    rgb_t bg;
    rgb_t pal;
    rgb_t colr;

    always_comb begin
        if (raster.sy < 20)       bg = rgb_t'(12'h239);
        else if (raster.sy < 40)  bg = rgb_t'(12'h24A);
        else if (raster.sy < 60)  bg = rgb_t'(12'h25B);
        else if (raster.sy < 80)  bg = rgb_t'(12'h26C);
        else if (raster.sy < 100) bg = rgb_t'(12'h27D);
        else                      bg = rgb_t'(12'h260);  // ground

        pal  = palette_rule(pix);
        colr = (drawing && pix != colr_idx_t'(`SPR_TRANS)) ? pal : bg;
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
        end else begin
            red   <= raster.de ? colr.r : 4'h0;
            green <= raster.de ? colr.g : 4'h0;
            blue  <= raster.de ? colr.b : 4'h0;
            hsync <= raster.hsync;  // keep syncs aligned with colour
            vsync <= raster.vsync;
            de    <= raster.de;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hedgehog_display.sv ====
// walking sprite demo, pixel-clock side only
// all outputs lag the raster counter by one clk_pix cycle
`default_nettype none
`timescale 1ns/1ps

module hedgehog_display
    import sprite_pkg::*;
(
    input  wire logic  clk_pix,
    input  wire logic  reset,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue,
    output logic       hsync,
    output logic       vsync,
    output logic       de
);

    coord_t    sprx;
    spr_addr_t base_addr;
    spr_addr_t pos;
    colr_idx_t rom_data;
    colr_idx_t pix;
    logic      start;
    logic      drawing;

    raster_if raster ();

    display_timings u_timings (
        .clk_pix,
        .reset,
        .raster
    );

    sprite_animator u_animator (
        .clk_pix,
        .reset,
        .raster,
        .sprx,
        .spry      (),
        .base_addr,
        .start
    );

    sprite_rom u_rom (
        .clk_pix,
        .addr (base_addr + pos),  // frame base plus offset in frame
        .data (rom_data)
    );

    sprite_engine u_engine (
        .clk_pix,
        .reset,
        .raster,
        .start,
        .sprx,
        .rom_data,
        .pos,
        .pix,
        .drawing,
        .done     ()
    );

    pixel_compositor u_compositor (
        .clk_pix,
        .reset,
        .raster,
        .pix,
        .drawing,
        .red,
        .green,
        .blue,
        .hsync,
        .vsync,
        .de
    );

endmodule

`default_nettype wire

// ==== verif/tb_hedgehog_display.sv ====
// full-raster compare of hedgehog_display against a model of bands, palette, ROM and walk
// run is long enough for the walk to clip at the left edge and wrap once
`timescale 1ns/1ps
`default_nettype none

`include "sprite_defs.svh"

module tb_hedgehog_display;

    localparam int FRAME_CYCLES = int'(`H_TOTAL) * int'(`V_TOTAL);
    localparam int FRAMES_MAIN  = 52;  // sprx 156 down to -40, wrap to 160, one more
    localparam int FRAMES_AFTER = 9;
    localparam int TIMEOUT      = (FRAMES_MAIN + FRAMES_AFTER + 3) * FRAME_CYCLES;

    logic       clk_pix;
    logic       reset;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;
    logic       vsync;
    logic       de;

    int       tx;           // raster position now shown at the ports
    int       ty;
    int       nframes;      // frame strobes since reset
    int       sprx_m;       // walk position of the model
    int       frames_done;
    int       de_cnt;
    int       errors;
    int       checks;
    int       spr_pix;
    int       cycles;
    bit       checking;
    bit       zero_check;
    bit       wrapped;      // model walk has wrapped since reset
    bit       wrap_seen;    // sprite shown correctly after a wrap
    bit       clip_seen;
    bit [2:0] sel_seen;

    hedgehog_display u_dut (
        .clk_pix, .reset,
        .red, .green, .blue,
        .hsync, .vsync, .de
    );

    function automatic logic [11:0] band_colour(input int y);
        if (y < 20) return 12'h239;
        if (y < 40) return 12'h24A;
        if (y < 60) return 12'h25B;
        if (y < 80) return 12'h26C;
        if (y < 100) return 12'h27D;
        return 12'h260;
    endfunction

    function automatic int rom_entry(input int f, input int r, input int c);
        if ((c + r) % 5 == 0) return `SPR_TRANS;
        return (3 * f + c + 2 * r) % 16;
    endfunction

    function automatic logic [11:0] palette_colour(input int i);
        return {4'(i), 4'(15 - i), 4'(5 * i)};
    endfunction

    // colour at an active pixel for animation frame sel and walk position s
    function automatic logic [11:0] expected_rgb(input int x, input int y, input int sel,
                                                 input int s);
        int idx;
        if (y >= `SPR_Y && y < `SPR_Y + `SPR_H * `SPR_SCALE
                && x >= s && x < s + `SPR_W * `SPR_SCALE) begin
            idx = rom_entry(sel, (y - `SPR_Y) / `SPR_SCALE, (x - s) / `SPR_SCALE);
            if (idx != `SPR_TRANS) return palette_colour(idx);
        end
        return band_colour(y);
    endfunction

    // after the first few, only a random sample of mismatches is printed
    task automatic check_val(input string name, input logic [11:0] got,
                             input logic [11:0] exp_v);
        checks++;
        if (got !== exp_v) begin
            errors++;
            if (errors <= 10 || $urandom_range(63) == 0) begin
                if (zero_check)
                    $display("MISMATCH %s during reset: got %h expected %h", name, got, exp_v);
                else
                    $display("MISMATCH %s at x=%0d y=%0d: got %h expected %h",
                             name, tx, ty, got, exp_v);
            end
        end
    endtask

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // sample the outputs on the falling edge
    always @(negedge clk_pix) begin
        logic [11:0] exp_c;
        bit          exp_de;
        if (zero_check) begin
            check_val("rgb", {red, green, blue}, 12'h000);
            check_val("de", de, 12'h0);
            check_val("hsync", hsync, 12'h0);
            check_val("vsync", vsync, 12'h0);
        end else if (checking) begin
            if (tx == 0 && ty == 0) begin  // frame strobe moves the model
                nframes++;
                if (sprx_m <= `SPR_LEFT_LIMIT) begin
                    sprx_m  = `SPR_START_X;
                    wrapped = 1'b1;
                end else begin
                    sprx_m = sprx_m - `SPR_SPEED;
                end
                de_cnt = 0;
            end
            exp_de = (tx < `H_ACTIVE) && (ty < `V_ACTIVE);
            exp_c  = exp_de ? expected_rgb(tx, ty, (nframes / `ANIM_PERIOD) % `SPR_FRAMES,
                                           sprx_m) : 12'h000;
            check_val("de", de, exp_de);
            check_val("hsync", hsync, (tx >= `HS_START) && (tx < `HS_END));
            check_val("vsync", vsync, (ty >= `VS_START) && (ty < `VS_END));
            check_val("rgb", {red, green, blue}, exp_c);
            if (exp_de) de_cnt++;
            // sprite pixel that the DUT actually shows
            if (exp_de && exp_c != band_colour(ty) && {red, green, blue} === exp_c) begin
                spr_pix++;
                sel_seen[(nframes / `ANIM_PERIOD) % `SPR_FRAMES] = 1'b1;
                if (sprx_m < 0) clip_seen = 1'b1;
                if (wrapped) wrap_seen = 1'b1;
            end
            if (tx == `H_TOTAL - 1) begin
                tx = 0;
                if (ty == `V_TOTAL - 1) begin
                    ty = 0;
                    frames_done++;
                    if (de_cnt != `H_ACTIVE * `V_ACTIVE) begin
                        errors++;
                        $display("MISMATCH de_count in frame %0d: got %h expected %h",
                                 frames_done, de_cnt, `H_ACTIVE * `V_ACTIVE);
                    end
                end else begin
                    ty++;
                end
            end else begin
                tx++;
            end
        end
    end

    // hold reset for 5 cycles and expect zero outputs meanwhile
    task automatic apply_reset;
        @(posedge clk_pix);
        checking = 1'b0;
        reset <= 1'b1;
        @(posedge clk_pix);
        zero_check = 1'b1;
        repeat (4) @(posedge clk_pix);
        reset <= 1'b0;
        @(posedge clk_pix);  // raster 0,0 now registered
        zero_check = 1'b0;
        tx       = 0;
        ty       = 0;
        nframes  = 0;
        sprx_m   = `SPR_START_X;
        wrapped  = 1'b0;
        checking = 1'b1;
    endtask

    initial begin
        int err_base;
        reset       = 1'b0;
        errors      = 0;
        checks      = 0;
        frames_done = 0;
        cycles      = 0;
        spr_pix     = 0;
        sel_seen    = '0;
        void'($urandom(15956));
        apply_reset();
        wait (frames_done == FRAMES_MAIN);
        $display("test 1 full raster, walk and animation, %0d frames: %0d errors",
                 FRAMES_MAIN, errors);
        err_base = errors;
        repeat (45 * `H_TOTAL + 37) @(posedge clk_pix);  // lands inside the sprite rows
        apply_reset();
        $display("test 2 reset mid-frame: %0d errors", errors - err_base);
        err_base = errors;
        wait (frames_done == FRAMES_MAIN + FRAMES_AFTER);
        $display("test 3 restart after reset, %0d frames: %0d errors",
                 FRAMES_AFTER, errors - err_base);
        if (spr_pix == 0 || sel_seen != 3'b111) begin
            errors++;
            $display("sprite did not show all three animation frames");
        end
        if (!clip_seen) begin
            errors++;
            $display("sprite was never seen clipped at the left edge");
        end
        if (!wrap_seen) begin
            errors++;
            $display("sprite was never seen back at the start position after the wrap");
        end
        $display("checks %0d, errors %0d, frames %0d, sprite pixels %0d",
                 checks, errors, frames_done, spr_pix);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hedgehog_display.f ====
+incdir+rtl
rtl/sprite_pkg.sv
rtl/raster_if.sv
rtl/display_timings.sv
rtl/sprite_rom.sv
rtl/sprite_animator.sv
rtl/sprite_engine.sv
rtl/pixel_compositor.sv
rtl/hedgehog_display.sv
verif/tb_hedgehog_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hedgehog_display testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_hedgehog_display \
    -f hedgehog_display.f -o sim_hedgehog
./obj_dir/sim_hedgehog > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
